// File: hdl/rvPkg.sv
`default_nettype none

package rvPkg;

  typedef logic [31:0] wordT;
  typedef logic [4:0]  regIdxT;

  // RV32I major opcodes in the supported subset
  typedef enum logic [6:0] {
    opcOp     = 7'b0110011,
    opcOpImm  = 7'b0010011,
    opcLoad   = 7'b0000011,
    opcStore  = 7'b0100011,
    opcBranch = 7'b1100011,
    opcJal    = 7'b1101111,
    opcSystem = 7'b1110011
  } opcodeT;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt
  } aluOpT;

  typedef enum logic [1:0] {
    resAlu,
    resMem,
    resPcPlus4
  } resultSrcT;

  typedef enum logic [1:0] {
    fwdReg,
    fwdWb,
    fwdMem
  } fwdSelT;

  typedef struct packed {
    wordT      rd1;
    wordT      rd2;
    wordT      imm;
    wordT      pc;
    wordT      pcPlus4;
    regIdxT    rs1;
    regIdxT    rs2;
    regIdxT    rd;
    logic      regWrite;
    logic      memWrite;
    logic      branch;
    logic      branchNe;
    logic      jump;
    logic      aluSrc;
    aluOpT     aluOp;
    resultSrcT resultSrc;
    logic      halt;
  } decExeT;

  typedef struct packed {
    wordT      aluResult;
    wordT      writeData;
    wordT      pcPlus4;
    regIdxT    rd;
    logic      regWrite;
    logic      memWrite;
    resultSrcT resultSrc;
    logic      halt;
  } exeMemT;

  typedef struct packed {
    wordT   result;
    regIdxT rd;
    logic   regWrite;
    logic   halt;
  } wbT;

  // Host address map
  localparam wordT ctrlAddr   = 32'h0000_0000;
  localparam wordT statusAddr = 32'h0000_0004;
  localparam wordT imemBase   = 32'h0000_1000;
  localparam wordT dmemBase   = 32'h0000_2000;

endpackage

`default_nettype wire

// File: hdl/rvFetch.sv
`timescale 1ns/1ps
`default_nettype none

module rvFetch #(
  parameter int imemWords = 256
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         run,
  input  logic                         stallF,
  input  logic                         stallD,
  input  logic                         flushD,
  input  logic                         redirect,
  input  rvPkg::wordT                  target,
  input  logic                         imemWe,
  input  logic [$clog2(imemWords)-1:0] imemAddr,
  input  rvPkg::wordT                  imemWdata,
  output rvPkg::wordT                  instrD,
  output rvPkg::wordT                  pcD
);
  import rvPkg::*;

  localparam int   aw       = $clog2(imemWords);
  localparam wordT nopInstr = 32'h0000_0013; // addi x0, x0, 0

  wordT imem [imemWords];
  wordT pcF;

  always_ff @(posedge clk) begin
    if (imemWe) begin
      imem[imemAddr] <= imemWdata; // Host load port
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcF <= '0;
    end else if (!run) begin
      pcF <= '0; // Next run starts at zero
    end else if (redirect) begin
      pcF <= target;
    end else if (!stallF) begin
      pcF <= pcF + 32'd4;
    end
  end

  // IF/ID register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      instrD <= nopInstr;
      pcD    <= '0;
    end else if (flushD || !run) begin
      instrD <= nopInstr; // Bubble
      pcD    <= '0;
    end else if (!stallD) begin
      instrD <= imem[pcF[aw+1:2]];
      pcD    <= pcF;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rvDecode.sv
`timescale 1ns/1ps
`default_nettype none

module rvDecode (
  input  logic          clk,
  input  logic          rstN,
  input  rvPkg::wordT   instrD,
  input  rvPkg::wordT   pcD,
  input  rvPkg::wbT     wb,
  output rvPkg::decExeT decOut,
  output rvPkg::regIdxT rs1D,
  output rvPkg::regIdxT rs2D
);
  import rvPkg::*;

  wordT       regs [32];
  opcodeT     opcode;
  logic [2:0] funct3;
  wordT       immI;
  wordT       immS;
  wordT       immB;
  wordT       immJ;

  assign opcode = opcodeT'(instrD[6:0]);
  assign funct3 = instrD[14:12];
  assign rs1D   = instrD[19:15];
  assign rs2D   = instrD[24:20];

  assign immI = {{20{instrD[31]}}, instrD[31:20]};
  assign immS = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
  assign immB = {{19{instrD[31]}}, instrD[31], instrD[7], instrD[30:25], instrD[11:8], 1'b0};
  assign immJ = {{11{instrD[31]}}, instrD[31], instrD[19:12], instrD[20], instrD[30:21], 1'b0};

  // Register file with x0 never written
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.regWrite && wb.rd != '0) begin
      regs[wb.rd] <= wb.result;
    end
  end

  // Same-cycle writeback wins over the stored value
  function automatic wordT readReg(regIdxT idx);
    if (idx == '0) return '0;
    if (wb.regWrite && wb.rd == idx) return wb.result;
    return regs[idx];
  endfunction

  function automatic aluOpT aluFromFunct3(logic [2:0] f3, logic subBit);
    case (f3)
      3'b000:  return subBit ? aluSub : aluAdd;
      3'b010:  return aluSlt;
      3'b100:  return aluXor;
      3'b110:  return aluOr;
      3'b111:  return aluAnd;
      default: return aluAdd;
    endcase
  endfunction

  always_comb begin
    decOut         = '0;
    decOut.rd1     = readReg(rs1D);
    decOut.rd2     = readReg(rs2D);
    decOut.pc      = pcD;
    decOut.pcPlus4 = pcD + 32'd4;
    decOut.rs1     = rs1D;
    decOut.rs2     = rs2D;
    decOut.rd      = instrD[11:7];
    case (opcode)
      opcOp: begin
        decOut.regWrite = 1'b1;
        decOut.aluOp    = aluFromFunct3(funct3, instrD[30]);
      end
      opcOpImm: begin
        decOut.regWrite = 1'b1;
        decOut.aluSrc   = 1'b1;
        decOut.imm      = immI;
        decOut.aluOp    = aluFromFunct3(funct3, 1'b0);
      end
      opcLoad: begin
        decOut.regWrite  = 1'b1;
        decOut.aluSrc    = 1'b1;
        decOut.imm       = immI;
        decOut.resultSrc = resMem;
      end
      opcStore: begin
        decOut.memWrite = 1'b1;
        decOut.aluSrc   = 1'b1;
        decOut.imm      = immS;
      end
      opcBranch: begin
        decOut.branch   = 1'b1;
        decOut.branchNe = funct3[0]; // BNE has funct3 001
        decOut.imm      = immB;
      end
      opcJal: begin
        decOut.regWrite  = 1'b1;
        decOut.jump      = 1'b1;
        decOut.imm       = immJ;
        decOut.resultSrc = resPcPlus4;
      end
      opcSystem: begin
        // ECALL jumps to itself until run drops, so nothing younger retires
        decOut.halt = 1'b1;
        decOut.jump = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rvExecute.sv
`timescale 1ns/1ps
`default_nettype none

module rvExecute (
  input  logic          clk,
  input  logic          rstN,
  input  rvPkg::decExeT decIn,
  input  logic          flushE,
  input  rvPkg::fwdSelT fwdA,
  input  rvPkg::fwdSelT fwdB,
  input  rvPkg::wordT   memAluResult,
  input  rvPkg::wordT   wbResult,
  output rvPkg::exeMemT exeOut,
  output logic          redirect,
  output rvPkg::wordT   target,
  output rvPkg::regIdxT rsE1,
  output rvPkg::regIdxT rsE2,
  output rvPkg::regIdxT rdE,
  output logic          loadE
);
  import rvPkg::*;

  decExeT decE;
  wordT   srcA;
  wordT   writeData;
  wordT   srcB;
  wordT   aluResult;
  logic   equal;

  // ID/EX register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      decE <= '0;
    end else if (flushE) begin
      decE <= '0; // Bubble
    end else begin
      decE <= decIn;
    end
  end

  function automatic wordT fwdMux(fwdSelT sel, wordT regVal);
    case (sel)
      fwdWb:   return wbResult;
      fwdMem:  return memAluResult;
      default: return regVal;
    endcase
  endfunction

  assign srcA      = fwdMux(fwdA, decE.rd1);
  assign writeData = fwdMux(fwdB, decE.rd2); // Also the store data
  assign srcB      = decE.aluSrc ? decE.imm : writeData;

  always_comb begin
    case (decE.aluOp)
      aluSub:  aluResult = srcA - srcB;
      aluAnd:  aluResult = srcA & srcB;
      aluOr:   aluResult = srcA | srcB;
      aluXor:  aluResult = srcA ^ srcB;
      aluSlt:  aluResult = {31'b0, $signed(srcA) < $signed(srcB)};
      default: aluResult = srcA + srcB;
    endcase
  end

  assign equal    = (srcA == writeData);
  assign redirect = decE.jump | (decE.branch & (equal ^ decE.branchNe));
  assign target   = decE.pc + decE.imm;

  // Hazard unit view of E
  assign rsE1  = decE.rs1;
  assign rsE2  = decE.rs2;
  assign rdE   = decE.rd;
  assign loadE = (decE.resultSrc == resMem);

  always_comb begin
    exeOut.aluResult = aluResult;
    exeOut.writeData = writeData;
    exeOut.pcPlus4   = decE.pcPlus4;
    exeOut.rd        = decE.rd;
    exeOut.regWrite  = decE.regWrite;
    exeOut.memWrite  = decE.memWrite;
    exeOut.resultSrc = decE.resultSrc;
    exeOut.halt      = decE.halt;
  end

endmodule

`default_nettype wire

// File: hdl/rvMemory.sv
`timescale 1ns/1ps
`default_nettype none

module rvMemory #(
  parameter int dmemWords = 256
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  rvPkg::exeMemT                exeIn,
  input  logic                         hostWe,
  input  logic [$clog2(dmemWords)-1:0] hostAddr,
  input  rvPkg::wordT                  hostWdata,
  output rvPkg::wordT                  hostRdata,
  output rvPkg::wordT                  memAluResult,
  output rvPkg::regIdxT                rdM,
  output logic                         regWriteM,
  output rvPkg::wbT                    wbOut
);
  import rvPkg::*;

  localparam int aw = $clog2(dmemWords);

  exeMemT exeM;
  wordT   dmem [dmemWords];
  wordT   loadData;
  wordT   result;

  // EX/MEM register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exeM <= '0;
    end else begin
      exeM <= exeIn;
    end
  end

  // Port A for the pipeline, port B for the host
  always_ff @(posedge clk) begin
    if (exeM.memWrite) begin
      dmem[exeM.aluResult[aw+1:2]] <= exeM.writeData;
    end
    if (hostWe) begin
      dmem[hostAddr] <= hostWdata;
    end
  end

  assign loadData  = dmem[exeM.aluResult[aw+1:2]];
  assign hostRdata = dmem[hostAddr];

  // JAL link value must forward too
  assign memAluResult = (exeM.resultSrc == resPcPlus4) ? exeM.pcPlus4 : exeM.aluResult;
  assign rdM          = exeM.rd;
  assign regWriteM    = exeM.regWrite;

  always_comb begin
    case (exeM.resultSrc)
      resMem:     result = loadData;
      resPcPlus4: result = exeM.pcPlus4;
      default:    result = exeM.aluResult;
    endcase
  end

  // MEM/WB register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbOut <= '0;
    end else begin
      wbOut.result   <= result;
      wbOut.rd       <= exeM.rd;
      wbOut.regWrite <= exeM.regWrite;
      wbOut.halt     <= exeM.halt;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rvHazard.sv
`timescale 1ns/1ps
`default_nettype none

module rvHazard (
  input  rvPkg::regIdxT rs1D,
  input  rvPkg::regIdxT rs2D,
  input  rvPkg::regIdxT rsE1,
  input  rvPkg::regIdxT rsE2,
  input  rvPkg::regIdxT rdE,
  input  logic          loadE,
  input  logic          redirect,
  input  rvPkg::regIdxT rdM,
  input  logic          regWriteM,
  input  rvPkg::regIdxT rdW,
  input  logic          regWriteW,
  output rvPkg::fwdSelT fwdA,
  output rvPkg::fwdSelT fwdB,
  output logic          stallF,
  output logic          stallD,
  output logic          flushD,
  output logic          flushE
);
  import rvPkg::*;

  logic loadUse;

  // Youngest producer wins
  function automatic fwdSelT pickFwd(regIdxT rs);
    if (regWriteM && rdM != '0 && rdM == rs) return fwdMem;
    if (regWriteW && rdW != '0 && rdW == rs) return fwdWb;
    return fwdReg;
  endfunction

  assign fwdA = pickFwd(rsE1);
  assign fwdB = pickFwd(rsE2);

  // Load result not ready until it reaches writeback
  assign loadUse = loadE && rdE != '0 && (rdE == rs1D || rdE == rs2D);

  assign stallF = loadUse;
  assign stallD = loadUse;
  assign flushD = redirect;
  assign flushE = loadUse | redirect;

endmodule

`default_nettype wire

// File: hdl/rvApbPort.sv
`timescale 1ns/1ps
`default_nettype none

module rvApbPort #(
  parameter int imemWords = 256,
  parameter int dmemWords = 256
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  rvPkg::wordT                  paddr,
  input  rvPkg::wordT                  pwdata,
  input  logic                         haltW,
  input  rvPkg::wordT                  hostRdata,
  output rvPkg::wordT                  prdata,
  output logic                         pready,
  output logic                         pslverr,
  output logic                         run,
  output logic                         imemWe,
  output logic [$clog2(imemWords)-1:0] imemAddr,
  output rvPkg::wordT                  imemWdata,
  output logic                         hostWe,
  output logic [$clog2(dmemWords)-1:0] hostAddr,
  output rvPkg::wordT                  hostWdata
);
  import rvPkg::*;

  localparam int ia = $clog2(imemWords);
  localparam int da = $clog2(dmemWords);

  logic access;
  logic hitCtrl, hitStatus, hitImem, hitDmem;
  logic done;
  wordT imemOff, dmemOff;

  assign access    = psel & penable;
  assign imemOff   = paddr - imemBase;
  assign dmemOff   = paddr - dmemBase;
  assign hitCtrl   = (paddr == ctrlAddr);
  assign hitStatus = (paddr == statusAddr);
  assign hitImem   = (paddr >= imemBase) && (imemOff < wordT'(imemWords * 4));
  assign hitDmem   = (paddr >= dmemBase) && (dmemOff < wordT'(dmemWords * 4));

  assign pready  = 1'b1; // No wait states
  assign pslverr = access & ~(hitCtrl | hitStatus | hitImem | hitDmem);

  assign imemWe    = access & pwrite & hitImem & ~run; // Program is frozen while running
  assign imemAddr  = imemOff[ia+1:2];
  assign imemWdata = pwdata;
  assign hostWe    = access & pwrite & hitDmem;
  assign hostAddr  = dmemOff[da+1:2];
  assign hostWdata = pwdata;

  always_comb begin
    if (hitCtrl)        prdata = {31'b0, run};
    else if (hitStatus) prdata = {31'b0, done};
    else if (hitDmem)   prdata = hostRdata;
    else                prdata = '0;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      run  <= 1'b0;
      done <= 1'b0;
    end else if (access && pwrite && hitCtrl) begin
      run <= pwdata[0];
      if (pwdata[0]) done <= 1'b0; // New run clears done
    end else if (haltW) begin
      run  <= 1'b0;
      done <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rvCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore #(
  parameter int imemWords = 256,
  parameter int dmemWords = 256
) (
  input  logic        clk,
  input  logic        rstN,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  rvPkg::wordT paddr,
  input  rvPkg::wordT pwdata,
  output rvPkg::wordT prdata,
  output logic        pready,
  output logic        pslverr
);
  import rvPkg::*;

  wordT   instrD, pcD;
  decExeT decOut;
  regIdxT rs1D, rs2D;
  exeMemT exeOut;
  logic   redirect;
  wordT   target;
  regIdxT rsE1, rsE2, rdE;
  logic   loadE;
  wordT   memAluResult;
  regIdxT rdM;
  logic   regWriteM;
  wbT     wbOut;
  fwdSelT fwdA, fwdB;
  logic   stallF, stallD, flushD, flushE;
  logic   run;
  logic   imemWe;
  logic [$clog2(imemWords)-1:0] imemAddr;
  wordT   imemWdata;
  logic   hostWe;
  logic [$clog2(dmemWords)-1:0] hostAddr;
  wordT   hostWdata, hostRdata;

  rvFetch #(.imemWords(imemWords)) fetch_i (
    .clk, .rstN, .run, .stallF, .stallD, .flushD, .redirect, .target,
    .imemWe, .imemAddr, .imemWdata, .instrD, .pcD
  );

  rvDecode decode_i (
    .clk, .rstN, .instrD, .pcD, .wb(wbOut), .decOut, .rs1D, .rs2D
  );

  rvExecute execute_i (
    .clk, .rstN, .decIn(decOut), .flushE, .fwdA, .fwdB, .memAluResult,
    .wbResult(wbOut.result), .exeOut, .redirect, .target, .rsE1, .rsE2, .rdE, .loadE
  );

  rvMemory #(.dmemWords(dmemWords)) memory_i (
    .clk, .rstN, .exeIn(exeOut), .hostWe, .hostAddr, .hostWdata, .hostRdata,
    .memAluResult, .rdM, .regWriteM, .wbOut
  );

  rvHazard hazard_i (
    .rs1D, .rs2D, .rsE1, .rsE2, .rdE, .loadE, .redirect, .rdM, .regWriteM,
    .rdW(wbOut.rd), .regWriteW(wbOut.regWrite),
    .fwdA, .fwdB, .stallF, .stallD, .flushD, .flushE
  );

  rvApbPort #(.imemWords(imemWords), .dmemWords(dmemWords)) apb_i (
    .clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata,
    .haltW(wbOut.halt), .hostRdata, .prdata, .pready, .pslverr, .run,
    .imemWe, .imemAddr, .imemWdata, .hostWe, .hostAddr, .hostWdata
  );

endmodule

`default_nettype wire

// File: testbench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
  parameter int period = 8
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: testbench/rvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;
  import rvPkg::*;

  localparam int   imemWords     = 256;
  localparam int   dmemWords     = 256;
  localparam int   checkWords    = 16; // Programs only touch the first words of data memory
  localparam int   progMax       = 64;
  localparam int   numPrograms   = 25;
  localparam int   apbPerProgram = 100;
  localparam int   timeoutCycles = numPrograms * (200 + 3 * apbPerProgram);
  localparam int   maxPolls      = 70;
  localparam wordT ecallWord     = 32'h0000_0073;

  logic clk;
  logic rstN;
  logic psel;
  logic penable;
  logic pwrite;
  wordT paddr;
  wordT pwdata;
  wordT prdata;
  logic pready;
  logic pslverr;

  wordT progBuf [progMax];
  int   progLen;
  wordT initMem [checkWords];
  wordT expMem  [checkWords];

  clockGen #(.period(8)) clockGen_i (.clk);

  rvCore #(.imemWords(imemWords), .dmemWords(dmemWords)) rvCore_i (
    .clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
  );

  function automatic wordT encodeR(logic [6:0] f7, regIdxT rs2, regIdxT rs1, logic [2:0] f3,
                                   regIdxT rd);
    return {f7, rs2, rs1, f3, rd, opcOp};
  endfunction

  function automatic wordT encodeI(logic [11:0] imm, regIdxT rs1, logic [2:0] f3, regIdxT rd,
                                   opcodeT opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic wordT encodeS(logic [11:0] imm, regIdxT rs2, regIdxT rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opcStore};
  endfunction

  function automatic wordT encodeB(logic [12:0] imm, regIdxT rs2, regIdxT rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcBranch};
  endfunction

  function automatic wordT encodeJ(logic [20:0] imm, regIdxT rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcJal};
  endfunction

  function automatic void emit(wordT w);
    progBuf[progLen] = w;
    progLen++;
  endfunction

  // Fill value mixes every address bit
  function automatic wordT fillWord(int i);
    wordT addr;
    addr = dmemBase + wordT'(i * 4);
    return addr ^ (addr << 13) ^ 32'hC3A5_0F1E;
  endfunction

  function automatic wordT aluModel(logic [2:0] f3, logic sub, wordT a, wordT b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return a + b;
    endcase
  endfunction

  // Sequential ISA model that leaves the expected memory in expMem
  function automatic void runModel();
    wordT r [32];
    wordT pc;
    wordT ins;
    wordT next;
    wordT addr;
    wordT immI;
    wordT immS;
    wordT immB;
    wordT immJ;
    for (int i = 0; i < 32; i++) r[i] = '0;
    expMem = initMem;
    pc = '0;
    for (int step = 0; step < 1000; step++) begin
      ins  = progBuf[pc[7:2]];
      immI = {{20{ins[31]}}, ins[31:20]};
      immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      next = pc + 32'd4;
      case (ins[6:0])
        opcOp:    r[ins[11:7]] = aluModel(ins[14:12], ins[30], r[ins[19:15]], r[ins[24:20]]);
        opcOpImm: r[ins[11:7]] = aluModel(ins[14:12], 1'b0, r[ins[19:15]], immI);
        opcLoad: begin
          addr = r[ins[19:15]] + immI;
          r[ins[11:7]] = expMem[addr[5:2]];
        end
        opcStore: begin
          addr = r[ins[19:15]] + immS;
          expMem[addr[5:2]] = r[ins[24:20]];
        end
        opcBranch: if ((r[ins[19:15]] == r[ins[24:20]]) != ins[12]) next = pc + immB;
        opcJal: begin
          r[ins[11:7]] = pc + 32'd4;
          next = pc + immJ;
        end
        opcSystem: return; // ECALL halts
        default: ;
      endcase
      r[0] = '0;
      pc = next;
    end
  endfunction

  task automatic checkWord(string name, wordT exp, wordT act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkStatus(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic apbWrite(wordT addr, wordT data, output logic err);
    @(posedge clk);
    psel    <= 1'b1; // Setup phase
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    err = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apbRead(wordT addr, output wordT data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata; // Mid access phase
    err  = pslverr;
    checkStatus("pready in access phase", 1'b1, pready);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic resetDut();
    @(posedge clk);
    rstN <= 1'b0;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
  endtask

  task automatic loadImage(bit randomInit);
    logic err;
    for (int i = 0; i < progLen; i++) begin
      apbWrite(imemBase + wordT'(i * 4), progBuf[i], err);
    end
    for (int i = 0; i < checkWords; i++) begin
      initMem[i] = randomInit ? wordT'($urandom) : fillWord(i);
      apbWrite(dmemBase + wordT'(i * 4), initMem[i], err);
    end
  endtask

  task automatic waitDone(string name);
    wordT data;
    logic err;
    int   polls;
    polls = 0;
    data  = '0;
    while (data[0] !== 1'b1) begin
      if (polls == maxPolls) begin
        $display("%s: core never reported done after %0d status polls", name, polls);
        $display("TESTS FAILED");
        $fatal(1);
      end else begin
        apbRead(statusAddr, data, err);
        polls++;
      end
    end
  endtask

  task automatic checkMemory(string name);
    wordT data;
    logic err;
    for (int i = 0; i < checkWords; i++) begin
      apbRead(dmemBase + wordT'(i * 4), data, err);
      checkWord($sformatf("%s dmem word %0d", name, i), expMem[i], data);
    end
  endtask

  task automatic runProgram(string name, bit randomInit);
    logic err;
    resetDut();
    loadImage(randomInit);
    apbWrite(ctrlAddr, 32'd1, err);
    waitDone(name);
    runModel();
    checkMemory(name);
  endtask

  function automatic void buildRandom();
    regIdxT      rd;
    regIdxT      rs1;
    regIdxT      rs2;
    logic [11:0] imm;
    progLen = 0;
    for (int r = 1; r < 8; r++) emit(encodeI(12'($urandom), 5'd0, 3'b000, regIdxT'(r), opcOpImm));
    for (int n = 0; n < 12; n++) begin
      rd  = regIdxT'($urandom_range(7, 1));
      rs1 = regIdxT'($urandom_range(7, 0));
      rs2 = regIdxT'($urandom_range(7, 0));
      imm = 12'($urandom);
      case ($urandom_range(8, 0))
        0:       emit(encodeR(7'b0000000, rs2, rs1, 3'b000, rd));
        1:       emit(encodeR(7'b0100000, rs2, rs1, 3'b000, rd)); // SUB
        2:       emit(encodeR(7'b0000000, rs2, rs1, 3'b111, rd));
        3:       emit(encodeR(7'b0000000, rs2, rs1, 3'b110, rd));
        4:       emit(encodeR(7'b0000000, rs2, rs1, 3'b100, rd));
        5:       emit(encodeR(7'b0000000, rs2, rs1, 3'b010, rd)); // SLT
        6:       emit(encodeI(imm, rs1, 3'b000, rd, opcOpImm));
        7:       emit(encodeI(imm, rs1, 3'b111, rd, opcOpImm));
        default: emit(encodeI(imm, rs1, 3'b110, rd, opcOpImm));
      endcase
    end
    for (int w = 0; w < 7; w++) emit(encodeS(12'(w * 4), regIdxT'(w + 1), 5'd0));
    emit(ecallWord);
  endfunction

  initial begin
    repeat (timeoutCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run is hung", timeoutCycles);
    $display("TESTS FAILED");
    $fatal(1);
  end

  initial begin
    wordT data;
    logic err;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    rstN    <= 1'b0;
    void'($urandom(12));
    repeat (2) @(posedge clk);
    rstN <= 1'b1;

    // APB registers
    apbRead(ctrlAddr, data, err);
    checkWord("ctrl after reset", 32'd0, data);
    checkStatus("ctrl read pslverr", 1'b0, err);
    apbRead(statusAddr, data, err);
    checkWord("status after reset", 32'd0, data);
    apbRead(32'h0000_2400, data, err); // Just past data memory
    checkStatus("unmapped read pslverr", 1'b1, err);
    apbWrite(32'h0000_0800, 32'hDEAD_BEEF, err);
    checkStatus("unmapped write pslverr", 1'b1, err);
    progLen = 0;
    for (int i = 0; i < 20; i++) emit(encodeI(12'd0, 5'd0, 3'b000, 5'd0, opcOpImm));
    emit(ecallWord);
    loadImage(1'b0);
    apbWrite(ctrlAddr, 32'd1, err);
    apbRead(ctrlAddr, data, err);
    checkWord("ctrl readback while running", 32'd1, data);
    waitDone("nop program");
    apbRead(ctrlAddr, data, err);
    checkWord("ctrl after halt", 32'd0, data);

    // Dependent ALU chain
    progLen = 0;
    emit(encodeI(12'd5, 5'd0, 3'b000, 5'd1, opcOpImm));
    emit(encodeI(12'hFFD, 5'd1, 3'b000, 5'd2, opcOpImm)); // x2 = x1 - 3
    emit(encodeR(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3));
    emit(encodeS(12'd0, 5'd3, 5'd0));
    emit(encodeR(7'b0100000, 5'd1, 5'd3, 3'b000, 5'd4));
    emit(encodeR(7'b0000000, 5'd4, 5'd3, 3'b100, 5'd5));
    emit(encodeR(7'b0000000, 5'd1, 5'd5, 3'b110, 5'd6));
    emit(encodeR(7'b0000000, 5'd3, 5'd6, 3'b111, 5'd7));
    emit(encodeS(12'd4, 5'd7, 5'd0));
    emit(encodeI(12'hFF9, 5'd0, 3'b000, 5'd9, opcOpImm));
    emit(encodeR(7'b0000000, 5'd1, 5'd9, 3'b010, 5'd10)); // Signed compare of -7
    emit(encodeI(12'h0F0, 5'd10, 3'b110, 5'd11, opcOpImm));
    emit(encodeI(12'h0F3, 5'd11, 3'b111, 5'd12, opcOpImm));
    for (int w = 2; w < 11; w++) emit(encodeS(12'(w * 4), regIdxT'(w + 2), 5'd0));
    emit(ecallWord);
    runProgram("alu chain", 1'b0);

    // Load-use
    progLen = 0;
    emit(encodeI(12'd0, 5'd0, 3'b010, 5'd1, opcLoad));
    emit(encodeR(7'b0000000, 5'd1, 5'd1, 3'b000, 5'd2));
    emit(encodeS(12'd4, 5'd2, 5'd0));
    emit(encodeI(12'd8, 5'd0, 3'b010, 5'd3, opcLoad));
    emit(encodeS(12'd12, 5'd3, 5'd0)); // Store data straight from a load
    emit(ecallWord);
    runProgram("load use", 1'b0);

    // Branches and jumps
    progLen = 0;
    emit(encodeI(12'd3, 5'd0, 3'b000, 5'd1, opcOpImm));
    emit(encodeI(12'd3, 5'd0, 3'b000, 5'd2, opcOpImm));
    emit(encodeB(13'd8, 5'd2, 5'd1, 3'b000)); // BEQ taken
    emit(encodeI(12'd99, 5'd0, 3'b000, 5'd3, opcOpImm));
    emit(encodeB(13'd8, 5'd2, 5'd1, 3'b001)); // BNE not taken
    emit(encodeI(12'd7, 5'd0, 3'b000, 5'd4, opcOpImm));
    emit(encodeB(13'd8, 5'd0, 5'd1, 3'b000));
    emit(encodeI(12'd11, 5'd0, 3'b000, 5'd5, opcOpImm));
    emit(encodeB(13'd12, 5'd0, 5'd1, 3'b001));
    emit(encodeI(12'd1, 5'd0, 3'b000, 5'd6, opcOpImm));
    emit(encodeI(12'd2, 5'd0, 3'b000, 5'd7, opcOpImm));
    emit(encodeJ(21'd12, 5'd8));
    emit(encodeI(12'd5, 5'd0, 3'b000, 5'd9, opcOpImm));
    emit(encodeI(12'd6, 5'd0, 3'b000, 5'd10, opcOpImm));
    for (int w = 0; w < 8; w++) emit(encodeS(12'(w * 4), regIdxT'(w + 3), 5'd0));
    emit(ecallWord);
    runProgram("branch jump", 1'b0);

    // Random programs
    for (int p = 0; p < 20; p++) begin
      buildRandom();
      runProgram($sformatf("random program %0d", p), 1'b1);
    end

    // Nothing after ECALL may store
    progLen = 0;
    emit(encodeI(12'd42, 5'd0, 3'b000, 5'd1, opcOpImm));
    emit(encodeS(12'd0, 5'd1, 5'd0));
    emit(ecallWord);
    emit(encodeS(12'd4, 5'd1, 5'd0));
    emit(encodeS(12'd8, 5'd1, 5'd0));
    runProgram("halt", 1'b0);
    repeat (30) @(posedge clk);
    apbRead(statusAddr, data, err);
    checkWord("status done after halt", 32'd1, data);
    apbRead(ctrlAddr, data, err);
    checkWord("ctrl run after halt", 32'd0, data);
    checkMemory("halt settled");

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rvCore.f
hdl/rvPkg.sv
hdl/rvFetch.sv
hdl/rvDecode.sv
hdl/rvExecute.sv
hdl/rvMemory.sv
hdl/rvHazard.sv
hdl/rvApbPort.sv
hdl/rvCore.sv
testbench/clockGen.sv
testbench/rvCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the rvCore testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing -f rvCore.f --top-module rvCoreTb -o rvCoreSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rvCoreSim > "$log" 2>&1
simStatus=$?
cat "$log"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "TESTS PASSED" "$log"; then
  exit 0
fi
echo "Pass message not found in $log"
exit 1
